// ==== Makefile ====
# Verilator flow for the envelope generator channel

VERILATOR  ?= verilator
TB_TOP     ?= eg_channel_tb
RTL_TOP    ?= eg_channel
FILELIST   ?= eg_channel.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== eg_channel.f ====
source/eg_pkg.sv
source/eg_timer.sv
source/eg_attack_step.sv
source/eg_decay_step.sv
source/eg_level_select.sv
source/eg_ctrl.sv
source/eg_channel.sv
verification/eg_clock_gen.sv
verification/eg_channel_tb.sv

// ==== source/eg_attack_step.sv ====
// attack path, exponential approach of attenuation toward zero
// result carries the borrow in its top bit
`timescale 1ns/100ps

module eg_attack_step (
    input  eg_pkg::eg_level_t eg_cur,
    input  eg_pkg::eg_rate_t  rate,
    input  logic              step,
    output eg_pkg::eg_wide_t  ar_result
);

    import eg_pkg::*;

    logic [3:0] r;
    logic [7:0] base;   // scaled down current level
    logic [8:0] inc;    // base plus one, so the level always reaches 0
    eg_level_t  sub;    // amount taken off this sample

    assign r = rate[4:1];

    always_comb begin
        // faster rates use a larger fraction of the level
        case (r)
            4'hb, 4'hc:       base = {1'b0, eg_cur[9:3]};
            4'hd, 4'he, 4'hf: base = eg_cur[9:2];
            default:          base = {2'b0, eg_cur[9:4]};
        endcase
        inc = {1'b0, base} + 9'd1;

        if (r == 4'he) begin
            sub = {inc, 1'b0};                       // always double
        end else if (r > 4'hb) begin
            sub = step ? {inc, 1'b0} : {1'b0, inc}; // C, D and F
        end else begin
            // lower rates take one inc per step, half the pace of the upper ones
            sub = step ? {1'b0, inc} : '0;
        end
    end

    assign ar_result = {1'b0, eg_cur} - {1'b0, sub}; // bit 10 set on borrow

endmodule

// ==== source/eg_channel.sv ====
// one envelope generator channel
// timer, attack and decay paths, combiner and phase control
`timescale 1ns/100ps

module eg_channel #(
    parameter int CNT_W = 15  // envelope counter width
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,      // one cycle sample strobe
    input  logic              keyon,
    input  eg_pkg::eg_regs_t  regs,
    output eg_pkg::eg_level_t eg_level,
    output eg_pkg::eg_phase_e phase
);

    import eg_pkg::*;

    eg_level_t  eg_cur;     // registered level
    eg_level_t  eg_next;    // level for the next sample
    eg_rate_t   rate;       // rate of the active phase
    eg_strobe_t strb;
    eg_wide_t   ar_result;
    eg_wide_t   dr_result;
    logic       attack;

    eg_timer #(
        .CNT_W (CNT_W)
    ) eg_timer_inst (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .rate (rate),
        .strb (strb)
    );

    eg_attack_step eg_attack_step_inst (
        .eg_cur    (eg_cur),
        .rate      (rate),
        .step      (strb.step),
        .ar_result (ar_result)
    );

    eg_decay_step eg_decay_step_inst (
        .eg_cur    (eg_cur),
        .rate      (rate),
        .step      (strb.step),
        .dr_result (dr_result)
    );

    eg_level_select eg_level_select_inst (
        .ar_result (ar_result),
        .dr_result (dr_result),
        .eg_cur    (eg_cur),
        .attack    (attack),
        .rate      (rate),
        .sum_up    (strb.sum_up),
        .eg_next   (eg_next)
    );

    eg_ctrl eg_ctrl_inst (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .keyon   (keyon),
        .regs    (regs),
        .eg_next (eg_next),
        .eg_cur  (eg_cur),
        .rate    (rate),
        .attack  (attack),
        .phase   (phase)
    );

    assign eg_level = eg_cur; // level changes one clk after each cen

endmodule

// ==== source/eg_ctrl.sv ====
// phase FSM with key on / key off handling
// rate selection and the attenuation register
`timescale 1ns/100ps

module eg_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              keyon,
    input  eg_pkg::eg_regs_t  regs,
    input  eg_pkg::eg_level_t eg_next,
    output eg_pkg::eg_level_t eg_cur,
    output eg_pkg::eg_rate_t  rate,
    output logic              attack,
    output eg_pkg::eg_phase_e phase
);

    import eg_pkg::*;

    logic     keyon_last;  // keyon seen on the previous sample
    eg_reg4_t rate_reg;    // register rate of the current phase

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= RELEASE;
            eg_cur     <= 10'h3ff; // silent out of reset
            keyon_last <= 1'b0;
        end else if (cen) begin
            keyon_last <= keyon;
            eg_cur     <= eg_next;
            if (keyon && !keyon_last) begin
                phase <= ATTACK;      // key on restarts the envelope
            end else if (!keyon) begin
                phase <= RELEASE;
            end else begin
                case (phase)
                    ATTACK: begin
                        if (eg_next == 10'd0)
                            phase <= DECAY;
                    end
                    DECAY: begin
                        if (eg_next[9:6] >= regs.sl) // sustain level in coarse steps
                            phase <= SUSTAIN;
                    end
                    default: begin
                        phase <= phase; // sustain and release hold until keyon changes
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (phase)
            ATTACK:  rate_reg = regs.ar;
            DECAY:   rate_reg = regs.dr;
            SUSTAIN: rate_reg = 4'd0;    // rate 0 keeps the level
            default: rate_reg = regs.rr;
        endcase
    end

    assign rate   = {rate_reg, regs.kbit};
    assign attack = (phase == ATTACK);

    // sustain ends only by a key event
    sustain_exit_a : assert property (
        @(posedge clk) disable iff (rst)
        phase == SUSTAIN |=> phase inside {SUSTAIN, RELEASE, ATTACK}
    ) else $error("phase left SUSTAIN toward DECAY");

endmodule

// ==== source/eg_decay_step.sv ====
// decay path, linear rise of attenuation toward 3FF
// result carries the carry in its top bit
`timescale 1ns/100ps

module eg_decay_step (
    input  eg_pkg::eg_level_t eg_cur,
    input  eg_pkg::eg_rate_t  rate,
    input  logic              step,
    output eg_pkg::eg_wide_t  dr_result
);

    logic [3:0] inc;  // added this sample

    always_comb begin
        case (rate[4:1])
            4'hc:    inc = {2'b0, step, ~step};        // 1 or 2
            4'hd:    inc = {1'b0, step, ~step, 1'b0};  // 2 or 4
            4'he:    inc = {step, ~step, 2'b0};        // 4 or 8
            4'hf:    inc = 4'd8;
            default: inc = {2'b0, step, 1'b0};         // 0 or 2
        endcase
    end

    assign dr_result = {1'b0, eg_cur} + {7'd0, inc};

    // decay never lowers the attenuation, even past the carry
    always_comb begin
        dr_rise_a : assert final (dr_result >= {1'b0, eg_cur})
            else $error("decay result below current level");
    end

endmodule

// ==== source/eg_level_select.sv ====
// combiner for the attack and decay results
// hold without sum_up, clamps at 0 and 3FF, instant attack at rate 1F
`timescale 1ns/100ps

module eg_level_select (
    input  eg_pkg::eg_wide_t  ar_result,
    input  eg_pkg::eg_wide_t  dr_result,
    input  eg_pkg::eg_level_t eg_cur,
    input  logic              attack,   // high in ATTACK
    input  eg_pkg::eg_rate_t  rate,
    input  logic              sum_up,
    output eg_pkg::eg_level_t eg_next
);

    import eg_pkg::*;

    eg_level_t pre_fast;  // level before the instant attack override

    always_comb begin
        if (!sum_up) begin
            pre_fast = eg_cur;                                  // no update this sample
        end else if (attack) begin
            pre_fast = ar_result[10] ? 10'd0 : ar_result[9:0];   // borrow clamps at loudest
        end else begin
            pre_fast = dr_result[10] ? 10'h3ff : dr_result[9:0]; // carry clamps at silent
        end
    end

    // top attack rate jumps straight to full volume
    assign eg_next = (attack && rate == 5'h1f) ? 10'd0 : pre_fast;

    // attack only ever makes the note louder
    always_comb begin
        attack_down_a : assert final (!attack || eg_next <= eg_cur)
            else $error("attack raised the attenuation");
    end

endmodule

// ==== source/eg_pkg.sv ====
// envelope generator types shared by all blocks
// level, rate and register field typedefs, phase enum
// strobe and register structs
package eg_pkg;

    typedef logic [9:0]  eg_level_t;  // attenuation, 0 loudest, 3FF silent
    typedef logic [10:0] eg_wide_t;   // level with borrow or carry on top
    typedef logic [4:0]  eg_rate_t;   // {register rate, key-scale bit}
    typedef logic [3:0]  eg_reg4_t;   // one envelope register field

    // envelope phases
    typedef enum logic [1:0] {
        ATTACK,
        DECAY,
        SUSTAIN,
        RELEASE
    } eg_phase_e;

    // timer strobes, only meaningful on cen cycles
    typedef struct packed {
        logic sum_up;  // level may change on this sample
        logic step;    // fine rate step
    } eg_strobe_t;

    // register values as seen by the channel
    typedef struct packed {
        eg_reg4_t ar;  // attack rate
        eg_reg4_t dr;  // decay rate
        eg_reg4_t sl;  // sustain level, compared with level[9:6]
        eg_reg4_t rr;  // release rate
        logic     kbit; // key-scale bit
    } eg_regs_t;

endpackage

// ==== source/eg_timer.sv ====
// global envelope counter
// sum_up and step strobe generation from counter and rate
`timescale 1ns/100ps

module eg_timer #(
    parameter int CNT_W = 15  // envelope counter width
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,   // sample strobe
    input  eg_pkg::eg_rate_t   rate,
    output eg_pkg::eg_strobe_t strb
);

    logic [CNT_W-1:0] cnt;       // global envelope counter
    logic [CNT_W-1:0] cnt_sh;    // counter shifted down by shift
    logic [CNT_W-1:0] low_mask;  // ones below bit position shift
    logic [3:0]       r;         // register part of the rate
    logic [3:0]       shift;
    logic [2:0]       idx;       // position in the step pattern
    logic [7:0]       pattern;

    // counter moves once per sample
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign r = rate[4:1];

    // slow rates look further up the counter
    assign shift = (r >= 4'd11) ? 4'd0 : 4'd11 - r;

    assign low_mask = ({{(CNT_W-1){1'b0}}, 1'b1} << shift) - 1'b1;
    assign cnt_sh   = cnt >> shift;
    assign idx      = cnt_sh[2:0];

    // key-scale adds the extra step per group of four
    assign pattern = rate[0] ? 8'b11101110 : 8'b10101010;

    always_comb begin
        strb.sum_up = (r != 4'd0) && ((cnt & low_mask) == '0); // rate 0 never moves
        strb.step   = pattern[3'd7 - idx];                       // index 0 is the msb
    end

    // between samples the counter must not move
    cnt_hold_a : assert property (
        @(posedge clk) disable iff (rst)
        !cen |=> $stable(cnt)
    ) else $error("envelope counter moved without cen");

endmodule

// ==== verification/eg_channel_tb.sv ====
// directed tests for one envelope generator channel
// reference model of counter, strobes, step paths, combiner and phases
// compare task, wait loops with timeouts and the closing summary
`timescale 1ns/100ps

module eg_channel_tb;

    import eg_pkg::*;

    localparam int CNT_W = 15;

    logic      clk, rst, cen, keyon;
    eg_regs_t  regs;
    eg_level_t eg_level;
    eg_phase_e phase;

    int        errors, tests, errs_before, held, n;
    int        m_cnt, m_level;  // model counter and level
    eg_phase_e m_phase;
    logic      m_kon_last;

    eg_clock_gen clock_gen_inst (.clk(clk), .rst(rst));

    eg_channel #(.CNT_W(CNT_W)) eg_channel_inst (
        .clk(clk), .rst(rst), .cen(cen), .keyon(keyon),
        .regs(regs), .eg_level(eg_level), .phase(phase)
    );

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // one sample of the update rules, using the inputs the DUT saw at this edge
    task automatic model_sample();
        int r, shift, idx, step, sum_up, base, inc, sub, inc_d, nxt;
        logic [7:0] pat;
        case (m_phase)
            ATTACK:  r = int'(regs.ar);
            DECAY:   r = int'(regs.dr);
            SUSTAIN: r = 0;
            default: r = int'(regs.rr);
        endcase
        shift  = (r > 11) ? 0 : 11 - r;
        sum_up = (r != 0 && (m_cnt % (1 << shift)) == 0) ? 1 : 0;
        idx    = (m_cnt >> shift) % 8;
        pat    = regs.kbit ? 8'b11101110 : 8'b10101010;
        step   = int'(pat[7 - idx]);  // index 0 is the leftmost bit
        // attack subtrahend, exponential in the level
        if (r >= 13) base = m_level >> 2;
        else if (r >= 11) base = m_level >> 3;
        else base = m_level >> 4;
        inc = base + 1;
        if (r == 14) sub = 2 * inc;
        else if (r >= 12) sub = step ? 2 * inc : inc;
        else sub = step ? inc : 0;
        case (r)  // decay increment
            12:      inc_d = 1 + step;
            13:      inc_d = 2 + 2 * step;
            14:      inc_d = 4 + 4 * step;
            15:      inc_d = 8;
            default: inc_d = 2 * step;
        endcase
        if (sum_up == 0) nxt = m_level;
        else if (m_phase == ATTACK) nxt = (sub > m_level) ? 0 : m_level - sub;
        else nxt = (m_level + inc_d > 'h3ff) ? 'h3ff : m_level + inc_d;
        if (m_phase == ATTACK && r == 15 && regs.kbit) nxt = 0;  // instant attack
        if (keyon && !m_kon_last) m_phase = ATTACK;
        else if (!keyon) m_phase = RELEASE;
        else if (m_phase == ATTACK && nxt == 0) m_phase = DECAY;
        else if (m_phase == DECAY && (nxt >> 6) >= int'(regs.sl)) m_phase = SUSTAIN;
        m_level    = nxt;
        m_kon_last = keyon;
        m_cnt      = (m_cnt + 1) % (1 << CNT_W);
    endtask

    // one cen pulse then three idle cycles, checked right after the pulse edge
    task automatic pulse_sample();
        cen = 1'b1;
        @(posedge clk);
        model_sample();
        #2;
        cen = 1'b0;
        check_value("eg_level", int'(eg_level), m_level);
        check_value("phase", int'(phase), int'(m_phase));
        repeat (3) @(posedge clk);
        #2;
    endtask

    task automatic wait_phase(input eg_phase_e target, input int limit);
        int cnt;
        cnt = 0;
        while (phase != target && cnt < limit) begin
            pulse_sample();
            cnt++;
        end
        if (phase != target) begin
            $display("phase did not reach %s within %0d samples", target.name(), limit);
            errors++;
        end
    endtask

    task automatic wait_level(input int target, input int limit);
        int cnt;
        cnt = 0;
        while (int'(eg_level) != target && cnt < limit) begin
            pulse_sample();
            cnt++;
        end
        if (int'(eg_level) != target) begin
            $display("level did not reach 0x%0h within %0d samples", target, limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
        errs_before = errors;
    endtask

    initial begin
        cen = 1'b0;
        keyon = 1'b0;
        regs = '0;
        errors = 0;
        tests = 0;
        errs_before = 0;
        m_cnt = 0;
        m_level = 'h3ff;
        m_phase = RELEASE;
        m_kon_last = 1'b0;
        void'($urandom(74447));
        n = 0;
        @(posedge clk);
        while (rst && n < 10) begin  // reset release, bounded
            @(posedge clk);
            n++;
        end
        if (rst) begin
            $display("reset never released");
            errors++;
        end
        #2;
        // 1: reset values, silent without key on
        check_value("eg_level", int'(eg_level), 'h3ff);
        check_value("phase", int'(phase), int'(RELEASE));
        repeat (50) pulse_sample();
        check_value("eg_level", int'(eg_level), 'h3ff);
        report_test("reset");
        // 2: attack at rate 9 down to 0, then decay
        regs.ar = 4'h9;
        keyon = 1'b1;
        wait_phase(DECAY, 3000);
        check_value("eg_level", int'(eg_level), 0);
        report_test("attack");
        // 3: release a little, then key on at the top attack rate
        keyon = 1'b0;
        regs.rr = 4'hf;
        repeat (10) pulse_sample();
        regs.ar = 4'hf;
        regs.kbit = 1'b1;
        keyon = 1'b1;
        pulse_sample();  // key on rise seen here
        pulse_sample();
        check_value("eg_level", int'(eg_level), 0);
        report_test("instant attack");
        // 4: decay at rate C up to sustain level 5, then hold
        regs.dr = 4'hc;
        regs.sl = 4'h5;
        wait_phase(SUSTAIN, 1000);
        held = int'(eg_level);
        repeat (100) begin
            pulse_sample();
            check_value("eg_level", int'(eg_level), held);
        end
        report_test("decay and sustain");
        // 5: key off with random registers, must saturate at 3FF
        regs.ar = 4'($urandom_range(15));
        regs.dr = 4'($urandom_range(15));
        regs.sl = 4'($urandom_range(15));
        regs.rr = 4'(10 + $urandom_range(5));  // fast enough to finish
        regs.kbit = 1'($urandom_range(1));
        keyon = 1'b0;
        wait_level('h3ff, 3000);
        repeat (20) pulse_sample();
        check_value("eg_level", int'(eg_level), 'h3ff);
        report_test("release");
        // 6: attack rate 0 leaves the level alone
        regs.ar = 4'h0;
        keyon = 1'b1;
        held = int'(eg_level);
        // spans two 2048 counter boundaries, one of them with step high
        repeat (4100) begin
            pulse_sample();
            check_value("eg_level", int'(eg_level), held);
        end
        report_test("zero rate");
        $display("summary: %0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/eg_clock_gen.sv ====
// clock and reset source for the testbench
// 20 ns period, reset held over two rising edges
`timescale 1ns/100ps

module eg_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;  // drops with the same skew as the stimulus
    end

endmodule
